//--- Makefile
# Verilator simulation of the UART peripheral, run from the project root

VERILATOR ?= verilator
TOP       ?= uartPeripheral_tb
FILELIST  ?= uartPeripheral.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= Finished with no errors

.PHONY: sim clean

# the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- src/baudTickGen.sv
// baudDivisor must be at least 1; at 1 the tick is high on every clock
`include "uart_params.svh"

module baudTickGen
#(
	parameter int baudDivisor = `baudDivDefault
)
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	localparam int cntW = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;
	localparam logic [cntW-1:0] lastCnt = cntW'(baudDivisor - 1);

	logic [cntW-1:0] divCnt;  // clocks since last tick

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick  <= 1'b0;
		end
		else if (divCnt == lastCnt)
		begin
			divCnt <= '0;    // wrap
			sTick  <= 1'b1;  // one clock wide
		end
		else
		begin
			divCnt <= divCnt + 1'b1;
			sTick  <= 1'b0;
		end
	end

	// framers count on isolated ticks
	generate
		if (baudDivisor > 1)
		begin : gTickCheck
			aSingleTick : assert property (@(posedge clk) disable iff (reset)
				sTick |=> !sTick);
		end
	endgenerate

endmodule

//--- src/uartFifo.sv
// depth is 2**fifoAddrLen; push when full and pop when empty are silently lost
`include "uart_params.svh"

module uartFifo
(
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  logic              pop,
	input  uartPkg::dataByte_t din,
	output uartPkg::dataByte_t dout,
	output logic              full,
	output logic              empty
);

	localparam int depthInt = 1 << `fifoAddrLen;
	localparam logic [`fifoAddrLen:0] fifoDepth = (`fifoAddrLen+1)'(depthInt);

	uartPkg::dataByte_t mem [depthInt];  // storage

	// one extra bit tells full from empty
	logic [`fifoAddrLen:0] wrPtr;
	logic [`fifoAddrLen:0] rdPtr;
	logic [`fifoAddrLen:0] count;

	logic doPush;
	logic doPop;

	assign count  = wrPtr - rdPtr;          // modulo arithmetic
	assign full   = (count == fifoDepth);
	assign empty  = (wrPtr == rdPtr);

	assign doPush = push && !full;          // overflow dropped
	assign doPop  = pop && !empty;          // underflow dropped

	// first word falls through
	assign dout = mem[rdPtr[`fifoAddrLen-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;  // push and pop together keep the count
		end
	end

	// payload write
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[`fifoAddrLen-1:0]] <= din;
	end

	aCountBound : assert property (@(posedge clk) disable iff (reset)
		count <= fifoDepth);

endmodule

//--- src/uartPeripheral.sv
// strobes act on the edge where they are high; a full rx FIFO loses the new byte and flags overrun
`include "uart_params.svh"

module uartPeripheral
#(
	parameter int baudDivisor = `baudDivDefault
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                txWr,
	input  uartPkg::dataByte_t   txData,
	input  logic                rxRd,
	input  logic                statRd,
	input  logic                rx,
	output logic                tx,
	output uartPkg::dataByte_t   rxData,
	output uartPkg::statusWord_t status
);

	logic sTick;

	// transmit side
	uartPkg::dataByte_t txHead;
	logic txRead, txBusy, txFull, txEmpty;

	// receive side
	uartPkg::dataByte_t rxByte;
	logic rxDone, frameBad, rxFull, rxEmpty, rxPush;

	// sticky flags
	logic overrun, frameErr;
	logic ovrSet, ferrSet;

	baudTickGen #(.baudDivisor(baudDivisor)) uBaud
	(
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	////////////////////////////////////////////////////////////////////////////
	// transmit path
	////////////////////////////////////////////////////////////////////////////

	uartFifo uTxFifo
	(
		.clk(clk), .reset(reset), .push(txWr), .pop(txRead),
		.din(txData), .dout(txHead), .full(txFull), .empty(txEmpty)
	);

	uartTrans uTrans
	(
		.clk(clk), .reset(reset), .sTick(sTick), .txStart(!txEmpty),
		.din(txHead), .tx(tx), .txRead(txRead), .txBusy(txBusy)
	);

	////////////////////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////////////////////

	uartRecv uRecv
	(
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxByte(rxByte), .rxDone(rxDone), .frameBad(frameBad)
	);

	assign rxPush  = rxDone && !frameBad && !rxFull;  // bad frames discarded
	assign ovrSet  = rxDone && !frameBad && rxFull;
	assign ferrSet = rxDone && frameBad;

	uartFifo uRxFifo
	(
		.clk(clk), .reset(reset), .push(rxPush), .pop(rxRd),
		.din(rxByte), .dout(rxData), .full(rxFull), .empty(rxEmpty)
	);

	// set beats clear
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun  <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			if (ovrSet)
				overrun <= 1'b1;
			else if (statRd)
				overrun <= 1'b0;
			if (ferrSet)
				frameErr <= 1'b1;
			else if (statRd)
				frameErr <= 1'b0;
		end
	end

	// status byte
	always_comb
	begin
		status.spare    = 1'b0;
		status.overrun  = overrun;
		status.frameErr = frameErr;
		status.txBusy   = txBusy;
		status.txFull   = txFull;
		status.txEmpty  = txEmpty;
		status.rxFull   = rxFull;
		status.rxEmpty  = rxEmpty;
	end

endmodule

//--- src/uartPkg.sv
// payload width follows the header; status bit order is fixed for host software
`include "uart_params.svh"

package uartPkg;

	// one payload byte
	typedef logic [`dataBits-1:0] dataByte_t;

	////////////////////////////////////////////////////////////////////////////
	// host status byte
	////////////////////////////////////////////////////////////////////////////

	// msb first
	typedef struct packed
	{
		logic spare;     // reads zero
		logic overrun;   // sticky
		logic frameErr;  // sticky
		logic txBusy;    // frame on the line
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
	} statusWord_t;

endpackage

//--- src/uartRecv.sv
// 8N1 only; rx is asynchronous and synchronized here, a glitch shorter than half a bit is dropped
`include "uart_params.svh"

module uartRecv
(
	input  logic              clk,
	input  logic              reset,
	input  logic              sTick,
	input  logic              rx,
	output uartPkg::dataByte_t rxByte,
	output logic              rxDone,
	output logic              frameBad
);

	localparam int tickW = $clog2((`sbTick > `overSample) ? `sbTick : `overSample);
	localparam int bitW  = $clog2(`dataBits);

	localparam logic [tickW-1:0] midBit  = tickW'(`overSample/2 - 1);
	localparam logic [tickW-1:0] bitEnd  = tickW'(`overSample - 1);
	localparam logic [tickW-1:0] stopEnd = tickW'(`sbTick - 1);
	localparam logic [bitW-1:0]  lastBit = bitW'(`dataBits - 1);

	typedef enum logic [1:0] {idle, start, data, stop} rxState_t;

	rxState_t stateReg, stateNext;
	logic [tickW-1:0] sReg, sNext;
	logic [bitW-1:0]  nReg, nNext;
	uartPkg::dataByte_t bReg, bNext;  // msb side fills first
	logic rxMeta, rxSync;             // two-flop synchronizer
	logic doneNext, badNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta   <= 1'b1;
			rxSync   <= 1'b1;
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			rxDone   <= 1'b0;
			frameBad <= 1'b0;
		end
		else
		begin
			rxMeta   <= rx;
			rxSync   <= rxMeta;
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			rxDone   <= doneNext;  // single pulse
			frameBad <= badNext;   // held until next frame ends
		end
	end

	// payload shifter
	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////////////
	// sampling FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		doneNext  = 1'b0;
		badNext   = frameBad;
		case (stateReg)
			idle:
			begin
				if (!rxSync)  // falling edge seen
				begin
					sNext     = '0;
					stateNext = start;
				end
			end
			start:
			begin
				if (sTick)
				begin
					if (sReg == midBit)
					begin
						sNext = '0;
						nNext = '0;
						// still low at mid-bit confirms it
						stateNext = rxSync ? idle : data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				if (sTick)
				begin
					if (sReg == bitEnd)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`dataBits-1:1]};  // lsb arrives first
						if (nReg == lastBit)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				if (sTick)
				begin
					if (sReg == stopEnd)
					begin
						doneNext  = 1'b1;
						badNext   = !rxSync;  // stop must be high
						stateNext = idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = idle;
		endcase
	end

	assign rxByte = bReg;

	aDonePulse : assert property (@(posedge clk) disable iff (reset)
		rxDone |=> !rxDone);

endmodule

//--- src/uartTrans.sv
// 8N1 only; din must be stable while txStart is high in idle and tx idles high
`include "uart_params.svh"

module uartTrans
(
	input  logic              clk,
	input  logic              reset,
	input  logic              sTick,
	input  logic              txStart,
	input  uartPkg::dataByte_t din,
	output logic              tx,
	output logic              txRead,
	output logic              txBusy
);

	localparam int tickW = $clog2((`sbTick > `overSample) ? `sbTick : `overSample);
	localparam int bitW  = $clog2(`dataBits);

	localparam logic [tickW-1:0] bitEnd  = tickW'(`overSample - 1);
	localparam logic [tickW-1:0] stopEnd = tickW'(`sbTick - 1);
	localparam logic [bitW-1:0]  lastBit = bitW'(`dataBits - 1);

	typedef enum logic [1:0] {idle, start, data, stop} txState_t;

	txState_t stateReg, stateNext;
	logic [tickW-1:0] sReg, sNext;     // ticks within bit
	logic [bitW-1:0]  nReg, nNext;     // data bit index
	uartPkg::dataByte_t bReg, bNext;   // shift register with lsb out first
	logic txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
			txReg    <= 1'b1;  // mark level
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
			txReg    <= txNext;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = txReg;
		txRead    = 1'b0;
		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txRead    = 1'b1;   // pop the word being latched
					bNext     = din;
					txNext    = 1'b0;   // start bit on next edge
					sNext     = '0;
					stateNext = start;
				end
			end
			start:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == bitEnd)
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];  // lsb first
				if (sTick)
				begin
					if (sReg == bitEnd)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == lastBit)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == stopEnd)
						stateNext = idle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = idle;
		endcase
	end

	assign tx     = txReg;
	assign txBusy = (stateReg != idle);

	// line rests at mark level between frames
	aIdleMark : assert property (@(posedge clk) disable iff (reset)
		!txBusy |-> tx);

endmodule

//--- src/uart_params.svh
// fixed 8N1 framing at 16x oversampling; the default divisor suits simulation only
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// frame format
////////////////////////////////////////////////////////////////////////////

`define dataBits        8   // payload bits per frame
`define sbTick          16  // ticks in one stop bit

// oversampling
`define overSample      16  // ticks per data bit

////////////////////////////////////////////////////////////////////////////
// buffering and baud
////////////////////////////////////////////////////////////////////////////

// address width of both FIFOs
// 4 gives 16 entries
`define fifoAddrLen     4

// clocks per oversampling tick
// real parts derive this from clock / (16 * baud)
`define baudDivDefault  4

`endif

//--- uartPeripheral.f
+incdir+src
src/uartPkg.sv
src/baudTickGen.sv
src/uartFifo.sv
src/uartTrans.sv
src/uartRecv.sv
src/uartPeripheral.sv
verification/uartPeripheral_tb.sv

//--- verification/uartPeripheral_tb.sv
// run from the project root so the test data path resolves; stops at the first mismatch
`include "uart_params.svh"

module uartPeripheral_tb;

	localparam int baudDiv     = `baudDivDefault;
	localparam int bitCycles   = `overSample * baudDiv;  // clocks per bit
	localparam int frameCycles = 10 * bitCycles;         // start, 8 data, stop

	logic                 clk;
	logic                 reset;
	logic                 txWr;
	uartPkg::dataByte_t   txData;
	logic                 rxRd;
	logic                 statRd;
	logic                 rx;
	logic                 tx;
	uartPkg::dataByte_t   rxData;
	uartPkg::statusWord_t status;

	logic rxLine;    // line model output
	logic loopback;  // rx fed from tx

	uartPkg::dataByte_t txExpect [$];  // bytes still due on tx
	int errorCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;                // armed once the test data is read

	assign rx = loopback ? tx : rxLine;

	uartPeripheral #(.baudDivisor(baudDiv)) uut
	(
		.clk(clk), .reset(reset), .txWr(txWr), .txData(txData), .rxRd(rxRd),
		.statRd(statRd), .rx(rx), .tx(tx), .rxData(rxData), .status(status)
	);

	////////////////////////////////////////////////////////////////////////////
	// reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic stopRun();
		$display("Finished with errors");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic valueError(string msg);
		errorCount++;
		$display("ERROR at %0t: %s", $time, msg);
		stopRun();
	endtask

	task automatic checkByte(string what, uartPkg::dataByte_t got, uartPkg::dataByte_t exp);
		if (got !== exp)
			valueError($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic checkStatus(uartPkg::statusWord_t got, uartPkg::statusWord_t exp,
			uartPkg::statusWord_t mask);
		logic [7:0] gotBits;
		logic [7:0] expBits;
		logic [7:0] maskBits;
		gotBits  = got;
		expBits  = exp;
		maskBits = mask;
		if ((gotBits & maskBits) !== (expBits & maskBits))
			valueError($sformatf("status is %h, expected %h under mask %h",
				gotBits, expBits, maskBits));
	endtask

	task automatic checkLine(string what, logic got, logic exp);
		if (got !== exp)
			valueError($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// k-th byte of a run counting up from first
	function automatic uartPkg::dataByte_t runByte(int first, int k);
		int v;
		v = first + k;
		return v[7:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host and line actions
	////////////////////////////////////////////////////////////////////////////

	// strobes set by the previous action act on this edge
	task automatic stepCycle();
		@(posedge clk);
		#10;
		txWr   = 1'b0;
		rxRd   = 1'b0;
		statRd = 1'b0;
	endtask

	task automatic writeRun(int first, int n, int kept);
		for (int k = 0; k < n; k++)
		begin
			stepCycle();
			txWr   = 1'b1;  // back to back writes
			txData = runByte(first, k);
			if (k < kept)
				txExpect.push_back(runByte(first, k));
		end
	endtask

	task automatic readRun(int first, int n);
		for (int k = 0; k < n; k++)
		begin
			stepCycle();
			while (status.rxEmpty)
				stepCycle();    // wait for the next received frame
			checkByte("rx FIFO head", rxData, runByte(first, k));
			rxRd = 1'b1;
		end
	endtask

	task automatic readStatus(int expVal, int maskVal);
		stepCycle();
		checkStatus(status, uartPkg::statusWord_t'(expVal[7:0]),
			uartPkg::statusWord_t'(maskVal[7:0]));
		statRd = 1'b1;  // sticky flags clear on this edge
	endtask

	task automatic holdLine(logic level, int n);
		rxLine = level;
		repeat (n)
			stepCycle();
	endtask

	task automatic sendFrame(uartPkg::dataByte_t data, logic goodStop);
		holdLine(1'b0, bitCycles);  // start
		for (int b = 0; b < `dataBits; b++)
			holdLine(data[b], bitCycles);  // lsb first
		if (goodStop)
			holdLine(1'b1, bitCycles);
		else
		begin
			// short low stop then high again before a false start is confirmed
			holdLine(1'b0, bitCycles * 3 / 4);
			holdLine(1'b1, bitCycles / 4);
		end
		holdLine(1'b1, bitCycles);  // idle bit
	endtask

	task automatic injectRun(int first, int n, logic goodStop);
		for (int k = 0; k < n; k++)
			sendFrame(runByte(first, k), goodStop);
	endtask

	task automatic waitIdle();
		stepCycle();
		while (!status.txEmpty || status.txBusy)
			stepCycle();
		repeat (bitCycles)
			stepCycle();            // receiver and monitor settle
		if (txExpect.size() != 0)
			valueError($sformatf("%0d written bytes never appeared on tx", txExpect.size()));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// clock, watchdog, tx monitor
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	initial
	begin : watchdog
		@(negedge reset);
		forever
		begin
			@(posedge clk);
			cycleCount++;
			if (cycleLimit > 0 && cycleCount > cycleLimit)
			begin
				$display("The run timed out after %0d cycles", cycleCount);
				stopRun();
			end
		end
	end

	// decodes each tx frame at bit centres
	initial
	begin : txMonitor
		uartPkg::dataByte_t got;
		@(negedge reset);
		forever
		begin
			@(negedge tx);
			repeat (bitCycles / 2)
				@(posedge clk);
			#10;
			checkLine("tx start bit", tx, 1'b0);
			for (int b = 0; b < `dataBits; b++)
			begin
				repeat (bitCycles)
					@(posedge clk);
				#10;
				got[b] = tx;
			end
			repeat (bitCycles)
				@(posedge clk);
			#10;
			checkLine("tx stop bit", tx, 1'b1);
			if (txExpect.size() == 0)
				valueError($sformatf("unexpected frame %h on tx", got));
			else
				checkByte("tx frame", got, txExpect.pop_front());
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// command loop
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : mainFlow
		int fd;
		int code;
		int val;
		int cnt;
		int aux;
		int totalOps;
		byte op;
		string line;
		byte cmdOp [$];
		int cmdVal [$];
		int cmdCnt [$];
		int cmdAux [$];

		reset    = 1'b1;
		txWr     = 1'b0;
		txData   = '0;
		rxRd     = 1'b0;
		statRd   = 1'b0;
		rxLine   = 1'b1;  // mark level
		loopback = 1'b0;
		totalOps = 0;

		fd = $fopen("verification/uart_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("The test data file could not be opened");
			stopRun();
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.substr(0, 0) != "#")
			begin
				if ($sscanf(line, "%c %h %h %h", op, val, cnt, aux) == 4)
				begin
					cmdOp.push_back(op);
					cmdVal.push_back(val);
					cmdCnt.push_back(cnt);
					cmdAux.push_back(aux);
					totalOps += cnt;
				end
			end
		end
		$fclose(fd);
		cycleLimit = totalOps * 2 * frameCycles + 4 * frameCycles;

		repeat (3)
			@(posedge clk);
		#10;
		reset = 1'b0;
		checkLine("tx after reset", tx, 1'b1);

		foreach (cmdOp[i])
		begin
			case (cmdOp[i])
				"W": writeRun(cmdVal[i], cmdCnt[i], cmdAux[i]);
				"R": readRun(cmdVal[i], cmdCnt[i]);
				"S": readStatus(cmdVal[i], cmdAux[i]);
				"I": injectRun(cmdVal[i], cmdCnt[i], 1'b1);
				"B": injectRun(cmdVal[i], cmdCnt[i], 1'b0);
				"X": waitIdle();
				"L":
				begin
					stepCycle();
					loopback = (cmdVal[i] != 0);
				end
				default:
				begin
					$display("The test data holds an unknown command %c", cmdOp[i]);
					stopRun();
				end
			endcase
		end
		stepCycle();  // last strobe acts

		if (errorCount == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
			stopRun();
	end

endmodule

//--- verification/uart_testdata.txt
# columns: op value count aux, all hex; W R I B act on count bytes from value upward
# W aux: bytes of the run expected on tx; S value: expected status, aux: mask; L value 1: loopback
S 05 01 ff
W a5 01 01
W 3c 01 01
X 00 01 00
S 05 01 ff
L 01 01 00
W 10 04 04
R 10 04 00
S 01 01 01
X 00 01 00
W 60 12 11
S 18 01 1c
R 60 11 00
X 00 01 00
S 05 01 ff
L 00 01 00
B 7e 01 00
S 21 01 23
S 01 01 23
I 80 11 00
S 42 01 43
R 80 10 00
S 01 01 63
X 00 01 00
